// File: flist.f
+incdir+verification
hw/system_pkg.sv
hw/reset_stretch.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_engine.sv
hw/system.sv
hw/top_system.sv
verification/tb_top_system.sv

// File: hw/cmd_engine.sv
module cmd_engine import system_pkg::*; (
   input  logic         sysclk,
   input  logic         reset,
   input  uart_strobe_t rx_byte,
   output uart_strobe_t tx_byte,
   output logic         trap
);

   typedef enum logic [1:0] {
      ST_OP,
      ST_ADDR,
      ST_DATA
   } cmd_state_t;

   cmd_state_t        state;
   logic              is_write;
   logic [ADDR_W-1:0] addr;
   logic [7:0]        mem [MEM_DEPTH];
   logic              accept;
   logic              addr_bad;

   // Nothing is taken once trapped
   assign accept   = rx_byte.strobe && !trap;
   assign addr_bad = (rx_byte.data >= 8'(MEM_DEPTH));

   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         state    <= ST_OP;
         is_write <= 1'b0;
         addr     <= '0;
         trap     <= 1'b0;
         tx_byte  <= '0;
      end else begin
         tx_byte.strobe <= 1'b0;
         if (accept) begin
            case (state)
               ST_OP: begin
                  if (rx_byte.data == OP_WRITE) begin
                     is_write <= 1'b1;
                     state    <= ST_ADDR;
                  end else if (rx_byte.data == OP_READ) begin
                     is_write <= 1'b0;
                     state    <= ST_ADDR;
                  end else begin
                     trap <= 1'b1;
                  end
               end
               ST_ADDR: begin
                  if (addr_bad) begin
                     trap  <= 1'b1;
                     state <= ST_OP;
                  end else if (is_write) begin
                     addr  <= rx_byte.data[ADDR_W-1:0];
                     state <= ST_DATA;
                  end else begin
                     // Read reply goes out the next cycle
                     tx_byte.strobe <= 1'b1;
                     tx_byte.data   <= mem[rx_byte.data[ADDR_W-1:0]];
                     state          <= ST_OP;
                  end
               end
               ST_DATA: begin
                  state <= ST_OP;
               end
               default: state <= ST_OP;
            endcase
         end
      end
   end

   // Memory comes up zeroed after every reset
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         mem <= '{default: '0};
      end else if (accept && state == ST_DATA) begin
         mem[addr] <= rx_byte.data;
      end
   end

endmodule

// File: hw/reset_stretch.sv
module reset_stretch import system_pkg::*; (
   input  logic sysclk,
   input  logic reset,
   output logic reset_int
);

   logic [HOLD_CNT_W-1:0] hold_cnt;

   // Saturating counter, restarted by every external reset
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         hold_cnt <= '0;
      end else if (hold_cnt != HOLD_CNT_W'(RESET_HOLD)) begin
         hold_cnt <= hold_cnt + 1'b1;
      end
   end

   // Registered so the release is glitch free
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         reset_int <= 1'b1;
      end else begin
         reset_int <= (hold_cnt != HOLD_CNT_W'(RESET_HOLD));
      end
   end

endmodule

// File: hw/system.sv
module system import system_pkg::*; (
   input  logic sysclk,
   input  logic reset,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic trap
);

   logic [1:0]   rxd_sync;
   uart_strobe_t rx_byte;
   uart_strobe_t tx_byte;

   // Two-stage synchronizer, idle high
   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         rxd_sync <= 2'b11;
      end else begin
         rxd_sync <= {rxd_sync[0], uart_rxd};
      end
   end

   uart_rx u_uart_rx (
      .sysclk  (sysclk),
      .reset   (reset),
      .rxd     (rxd_sync[1]),
      .rx_byte (rx_byte)
   );

   cmd_engine u_cmd_engine (
      .sysclk  (sysclk),
      .reset   (reset),
      .rx_byte (rx_byte),
      .tx_byte (tx_byte),
      .trap    (trap)
   );

   uart_tx u_uart_tx (
      .sysclk  (sysclk),
      .reset   (reset),
      .tx_byte (tx_byte),
      .txd     (uart_txd)
   );

endmodule

// File: hw/system_pkg.sv
package system_pkg;

   // UART bit period in sysclk cycles, kept short for simulation
   localparam int CLKS_PER_BIT = 8;
   localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

   // Internal reset hold after external release
   localparam int RESET_HOLD   = 64;
   localparam int HOLD_CNT_W   = $clog2(RESET_HOLD + 1);

   // Command engine memory
   localparam int MEM_DEPTH    = 16;
   localparam int ADDR_W       = $clog2(MEM_DEPTH);

   // Command opcodes
   localparam logic [7:0] OP_WRITE = 8'h57;
   localparam logic [7:0] OP_READ  = 8'h52;

   // One byte transfer, strobe high for a single cycle
   typedef struct packed {
      logic       strobe;
      logic [7:0] data;
   } uart_strobe_t;

endpackage

// File: hw/top_system.sv
module top_system (
   input  logic sysclk,
   input  logic reset,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic trap
);

   logic reset_int;

   // Clean synchronous release of the internal reset
   reset_stretch u_reset_stretch (
      .sysclk    (sysclk),
      .reset     (reset),
      .reset_int (reset_int)
   );

   system u_system (
      .sysclk   (sysclk),
      .reset    (reset_int),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .trap     (trap)
   );

endmodule

// File: hw/uart_rx.sv
module uart_rx import system_pkg::*; (
   input  logic         sysclk,
   input  logic         reset,
   input  logic         rxd,
   output uart_strobe_t rx_byte
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t            state;
   logic [BIT_CNT_W-1:0] clk_cnt;
   logic [2:0]           bit_idx;
   logic [7:0]           shift;
   logic                 rxd_prev;

   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         state          <= RX_IDLE;
         clk_cnt        <= '0;
         bit_idx        <= '0;
         shift          <= '0;
         rxd_prev       <= 1'b1;
         rx_byte.strobe <= 1'b0;
         rx_byte.data   <= '0;
      end else begin
         rxd_prev       <= rxd;
         rx_byte.strobe <= 1'b0;
         case (state)
            RX_IDLE: begin
               // Falling edge only, so a stuck-low line does not retrigger
               if (rxd_prev && !rxd) begin
                  state   <= RX_START;
                  clk_cnt <= '0;
               end
            end
            RX_START: begin
               if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  // Re-check at mid-bit to reject glitches
                  state   <= rxd ? RX_IDLE : RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                  clk_cnt <= '0;
                  // LSB first
                  shift   <= {rxd, shift[7:1]};
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
                  clk_cnt <= '0;
                  state   <= RX_IDLE;
                  if (rxd) begin
                     rx_byte.strobe <= 1'b1;
                     rx_byte.data   <= shift;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

// File: hw/uart_tx.sv
module uart_tx import system_pkg::*; (
   input  logic         sysclk,
   input  logic         reset,
   input  uart_strobe_t tx_byte,
   output logic         txd
);

   logic [9:0]           frame;
   logic                 busy;
   logic [BIT_CNT_W-1:0] clk_cnt;
   logic [3:0]           bit_idx;

   always_ff @(posedge sysclk or posedge reset) begin
      if (reset) begin
         // All ones keeps the line idle
         frame   <= '1;
         busy    <= 1'b0;
         clk_cnt <= '0;
         bit_idx <= '0;
      end else if (!busy) begin
         if (tx_byte.strobe) begin
            // Stop, data, start
            frame   <= {1'b1, tx_byte.data, 1'b0};
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
         end
      end else if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
         clk_cnt <= '0;
         frame   <= {1'b1, frame[9:1]};
         if (bit_idx == 4'd9) begin
            busy <= 1'b0;
         end else begin
            bit_idx <= bit_idx + 1'b1;
         end
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   assign txd = frame[0];

endmodule

// File: verification/uart_bfm.svh
`ifndef UART_BFM_SVH
`define UART_BFM_SVH

// Bit-level UART tasks, included inside the testbench module

// Advance n clocks and land just after the rising edge
task automatic wait_clocks(input int n);
   repeat (n) @(posedge sysclk);
   #2;
endtask

// One 8N1 frame on uart_rxd, stop bit low when good_stop is clear
task automatic send_frame(input logic [7:0] data, input bit good_stop);
   logic [9:0] bits;
   bits = {good_stop, data, 1'b0};
   for (int i = 0; i < 10; i++) begin
      uart_rxd = bits[i];
      wait_clocks(CLKS_PER_BIT);
   end
endtask

// Idle line for a number of bit times
task automatic send_idle(input int nbits);
   uart_rxd = 1'b1;
   wait_clocks(nbits * CLKS_PER_BIT);
endtask

// Runs forever, one queue entry per reply frame on uart_txd
task automatic collect_replies();
   logic [7:0] data;
   forever begin
      @(negedge uart_txd);
      // Middle of the start bit, away from the registered edges
      repeat (CLKS_PER_BIT / 2) @(negedge sysclk);
      if (uart_txd == 1'b0) begin
         for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge sysclk);
            data[i] = uart_txd;
         end
         repeat (CLKS_PER_BIT) @(negedge sysclk);
         check_count++;
         assert (uart_txd === 1'b1) else begin
            error_count++;
            $display("reply frame on uart_txd ended with a low stop bit");
         end
         reply_q.push_back(data);
      end
   end
endtask

`endif

// File: verification/tb_top_system.sv
module tb_top_system import system_pkg::*; ();

   localparam int N_RANDOM   = 200;
   localparam int N_BAD_STOP = 4;
   // Reads after two resets, random commands, bad stop rounds, trap round
   localparam int MAX_FRAMES = 4 * MEM_DEPTH + 3 * N_RANDOM + 8 * N_BAD_STOP + 8;
   localparam int TIMEOUT_CYCLES = MAX_FRAMES * 10 * CLKS_PER_BIT * 2 + 2000;

   logic       sysclk;
   logic       reset;
   logic       uart_rxd;
   logic       uart_txd;
   logic       trap;
   logic [7:0] reply_q[$];
   logic [7:0] expect_q[$];
   logic [7:0] model_mem[MEM_DEPTH];
   bit         model_trap;
   int         error_count = 0;
   int         check_count = 0;
   int         cycle_count = 0;
   integer     seed = 30319;

   `include "uart_bfm.svh"

   top_system DUT (
      .sysclk   (sysclk),
      .reset    (reset),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .trap     (trap)
   );

   initial sysclk = 1'b0;
   always #20 sysclk = ~sysclk;

   always @(posedge sysclk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, DUT stopped responding", cycle_count);
         $display("checks %0d, errors %0d", check_count, error_count + 1);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // External reset, then watch the outputs through the internal hold
   task automatic apply_reset();
      reset = 1'b1;
      wait_clocks(16);
      reset = 1'b0;
      foreach (model_mem[i]) model_mem[i] = 8'h00;
      model_trap = 1'b0;
      expect_q.delete();
      reply_q.delete();
      repeat (RESET_HOLD + 8) begin
         @(negedge sysclk);
         check_count++;
         assert (uart_txd === 1'b1) else begin
            error_count++;
            $display("error uart_txd expected %h got %h", 1'b1, uart_txd);
         end
         assert (trap === 1'b0) else begin
            error_count++;
            $display("error trap expected %h got %h", 1'b0, trap);
         end
      end
      wait_clocks(1);
   endtask

   task automatic write_cmd(input logic [7:0] addr, input logic [7:0] data);
      send_frame(OP_WRITE, 1'b1);
      send_frame(addr, 1'b1);
      send_frame(data, 1'b1);
      if (!model_trap) model_mem[addr] = data;
   endtask

   task automatic read_cmd(input logic [7:0] addr);
      send_frame(OP_READ, 1'b1);
      send_frame(addr, 1'b1);
      if (!model_trap) expect_q.push_back(model_mem[addr]);
   endtask

   // Wait for all expected replies, then one more frame for extras
   task automatic check_replies();
      logic [7:0] exp;
      logic [7:0] got;
      while (reply_q.size() < expect_q.size()) @(posedge sysclk);
      wait_clocks(12 * CLKS_PER_BIT);
      check_count++;
      assert (reply_q.size() == expect_q.size()) else begin
         error_count++;
         $display("%0d replies received but %0d expected", reply_q.size(), expect_q.size());
      end
      while (expect_q.size() > 0 && reply_q.size() > 0) begin
         exp = expect_q.pop_front();
         got = reply_q.pop_front();
         check_count++;
         assert (got === exp) else begin
            error_count++;
            $display("error uart_txd expected %h got %h", exp, got);
         end
      end
      expect_q.delete();
      reply_q.delete();
   endtask

   initial begin
      logic [7:0] addr;
      logic [7:0] data;
      logic [7:0] bad;
      reset    = 1'b1;
      uart_rxd = 1'b1;
      fork
         collect_replies();
      join_none
      apply_reset();

      // Fresh memory reads back zero
      for (int a = 0; a < MEM_DEPTH; a++) read_cmd(8'(a));
      check_replies();

      // Random mix, frames sent back to back
      repeat (N_RANDOM) begin
         addr = $random(seed) & (MEM_DEPTH - 1);
         data = $random(seed);
         if (data[0]) write_cmd(addr, $random(seed));
         else read_cmd(addr);
      end
      check_replies();

      // Frames with a low stop bit must be dropped
      repeat (N_BAD_STOP) begin
         do bad = $random(seed); while (bad == OP_WRITE || bad == OP_READ);
         send_frame(bad, 1'b0);
         send_idle(2);
         addr = $random(seed) & (MEM_DEPTH - 1);
         write_cmd(addr, $random(seed));
         read_cmd(addr);
      end
      check_replies();

      data = $random(seed);
      if (data[0]) begin
         do bad = $random(seed); while (bad == OP_WRITE || bad == OP_READ);
         send_frame(bad, 1'b1);
      end else begin
         send_frame(data[1] ? OP_WRITE : OP_READ, 1'b1);
         bad = 8'(MEM_DEPTH) + ($random(seed) & 8'h7f);
         send_frame(bad, 1'b1);
      end
      @(negedge sysclk);
      check_count++;
      assert (trap === 1'b1) else begin
         error_count++;
         $display("error trap expected %h got %h", 1'b1, trap);
      end
      model_trap = 1'b1;
      wait_clocks(1);
      read_cmd($random(seed) & (MEM_DEPTH - 1));
      read_cmd($random(seed) & (MEM_DEPTH - 1));
      wait_clocks(12 * CLKS_PER_BIT);
      check_count++;
      assert (reply_q.size() == 0) else begin
         error_count++;
         $display("a reply appeared on uart_txd while trap was set");
      end

      // Second reset clears trap and memory
      apply_reset();
      for (int a = 0; a < MEM_DEPTH; a++) read_cmd(8'(a));
      check_replies();

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
